// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= vrf_tb
FLIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -Wno-fatal
RUNFLAGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG) || ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/vrf_bank.sv ====
/* Single bank with one read and one write port.
   Read data appears the cycle after i_ren and shows the contents from before
   a write at the same edge. Contents are undefined after power-up. */

module vrf_bank #(
    parameter type row_t = logic [63:0],
    parameter int NROWS = 8
)(
    input  logic CLK,
    input  logic i_ren,
    input  logic [$clog2(NROWS)-1:0] i_raddr,
    output row_t o_rdata,
    input  logic i_wen,
    input  logic [$clog2(NROWS)-1:0] i_waddr,
    input  row_t i_wdata
);

    row_t mem [NROWS];

    always_ff @(posedge CLK) begin
        if (i_ren) begin
            o_rdata <= mem[i_raddr];
        end
    end

    always_ff @(posedge CLK) begin
        if (i_wen) begin
            mem[i_waddr] <= i_wdata;
        end
    end

endmodule

// ==== hw/vrf_banked.sv ====
/* Banked register file. Bank is the low bits of the register number.
   Same-bank requests are served lowest port first, the rest from pending masks
   while busy is high. Writes wait behind later reads of their bank, so every
   read of a request set sees the data from before that set. */
`include "vrf_cfg.svh"

module vrf_banked
    import vrf_pkg::*;
(
    input logic CLK,
    input logic nRST,
    vrf_if.regfile vif
);

    localparam int BW = $clog2(`VRF_BANKS);
    localparam int MBW = $clog2(`VRF_MBANKS);
    localparam int DROWS = `VRF_NREGS / `VRF_BANKS;
    localparam int MROWS = `VRF_NMASKS / `VRF_MBANKS;
    localparam int DRW = $clog2(DROWS);
    localparam int MRW = $clog2(MROWS);

    conflict_state_t state, state_nxt;
    vrf_req_t req_q, cur;

    logic [`VRF_RPORTS-1:0] rreqs [`VRF_BANKS];
    logic [`VRF_RPORTS-1:0] rpend [`VRF_BANKS];
    logic [`VRF_RPORTS-1:0] rpend_nxt [`VRF_BANKS];
    logic [`VRF_WPORTS-1:0] wreqs [`VRF_BANKS];
    logic [`VRF_WPORTS-1:0] wpend [`VRF_BANKS];
    logic [`VRF_WPORTS-1:0] wpend_nxt [`VRF_BANKS];

    logic [`VRF_BANKS-1:0] b_ren, b_wen;
    logic [DRW-1:0] b_raddr [`VRF_BANKS];
    logic [DRW-1:0] b_waddr [`VRF_BANKS];
    vreg_t b_wdata [`VRF_BANKS];
    vreg_t b_rdata [`VRF_BANKS];

    // Port tag of each bank read, used when the data comes back
    logic [`VRF_RPORTS-1:0] rtag [`VRF_BANKS];
    logic [`VRF_RPORTS-1:0] rtag_q [`VRF_BANKS];
    logic [`VRF_BANKS-1:0] rvld_q;

    logic mren, mwen;
    logic [`VRF_MBANKS-1:0] mb_ren, mb_wen;
    vmask_t mb_rdata [`VRF_MBANKS];
    logic [MBW-1:0] msel_q;
    logic mvld_q;

    always_comb begin
        logic [`VRF_RPORTS-1:0] rwin;
        logic [`VRF_WPORTS-1:0] wwin;
        logic pending;

        cur = (state == CONFLICT) ? req_q : vif.req;
        for (int b = 0; b < `VRF_BANKS; b++) begin
            rreqs[b] = '0;
            wreqs[b] = '0;
        end
        if (state == CONFLICT) begin
            rreqs = rpend;
            wreqs = wpend;
        end else if (vif.req_valid) begin
            for (int p = 0; p < `VRF_RPORTS; p++) begin
                if (cur.ren[p]) rreqs[cur.vs[p][BW-1:0]][p] = 1'b1;
            end
            for (int p = 0; p < `VRF_WPORTS; p++) begin
                if (cur.wen[p]) wreqs[cur.vd[p][BW-1:0]][p] = 1'b1;
            end
        end
        rpend_nxt = rreqs;
        wpend_nxt = wreqs;

        for (int b = 0; b < `VRF_BANKS; b++) begin
            b_ren[b] = 1'b0;
            b_wen[b] = 1'b0;
            b_raddr[b] = '0;
            b_waddr[b] = '0;
            b_wdata[b] = '0;
            rtag[b] = '0;
            // Lowest requesting port wins
            rwin = rreqs[b] & (~rreqs[b] + 1'b1);
            if (|rreqs[b]) begin
                b_ren[b] = 1'b1;
                rtag[b] = rwin;
                for (int p = 0; p < `VRF_RPORTS; p++) begin
                    if (rwin[p]) b_raddr[b] = DRW'(cur.vs[p] >> BW);
                end
                rpend_nxt[b] = rreqs[b] & ~rwin;
            end
            wwin = wreqs[b] & (~wreqs[b] + 1'b1);
            if (|wreqs[b] && rpend_nxt[b] == '0) begin
                b_wen[b] = 1'b1;
                for (int p = 0; p < `VRF_WPORTS; p++) begin
                    if (wwin[p]) begin
                        b_waddr[b] = DRW'(cur.vd[p] >> BW);
                        b_wdata[b] = cur.wdata[p];
                    end
                end
                wpend_nxt[b] = wreqs[b] & ~wwin;
            end
        end

        pending = 1'b0;
        for (int b = 0; b < `VRF_BANKS; b++) begin
            pending = pending || (|rpend_nxt[b]) || (|wpend_nxt[b]);
        end
        state_nxt = pending ? CONFLICT : READY;
    end

    // Single mask ports never conflict, so they only go out with a new set
    assign mren = vif.req_valid && vif.req.mren;
    assign mwen = vif.req_valid && vif.req.mwen;

    always_comb begin
        for (int m = 0; m < `VRF_MBANKS; m++) begin
            mb_ren[m] = mren && (vif.req.vms[MBW-1:0] == MBW'(m));
            mb_wen[m] = mwen && (vif.req.vmd[MBW-1:0] == MBW'(m));
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= READY;
            rpend <= '{default: '0};
            wpend <= '{default: '0};
            rvld_q <= '0;
            mvld_q <= 1'b0;
        end else begin
            state <= state_nxt;
            rpend <= rpend_nxt;
            wpend <= wpend_nxt;
            rvld_q <= b_ren;
            mvld_q <= mren;
        end
    end

    always_ff @(posedge CLK) begin
        if (vif.req_valid) begin
            req_q <= vif.req;
        end
        rtag_q <= rtag;
        msel_q <= vif.req.vms[MBW-1:0];
    end

    assign vif.busy = (state == CONFLICT);

    for (genvar b = 0; b < `VRF_BANKS; b++) begin : g_dbank
        vrf_bank #(
            .row_t (vreg_t),
            .NROWS (DROWS)
        ) bank_i (
            .CLK     (CLK),
            .i_ren   (b_ren[b]),
            .i_raddr (b_raddr[b]),
            .o_rdata (b_rdata[b]),
            .i_wen   (b_wen[b]),
            .i_waddr (b_waddr[b]),
            .i_wdata (b_wdata[b])
        );
    end

    for (genvar m = 0; m < `VRF_MBANKS; m++) begin : g_mbank
        vrf_bank #(
            .row_t (vmask_t),
            .NROWS (MROWS)
        ) bank_i (
            .CLK     (CLK),
            .i_ren   (mb_ren[m]),
            .i_raddr (MRW'(vif.req.vms >> MBW)),
            .o_rdata (mb_rdata[m]),
            .i_wen   (mb_wen[m]),
            .i_waddr (MRW'(vif.req.vmd >> MBW)),
            .i_wdata (vif.req.mwdata)
        );
    end

    // Steer returning bank data to the port that asked for it
    always_comb begin
        vif.rdata = '0;
        vif.dvalid = '0;
        for (int b = 0; b < `VRF_BANKS; b++) begin
            for (int p = 0; p < `VRF_RPORTS; p++) begin
                if (rvld_q[b] && rtag_q[b][p]) begin
                    vif.rdata[p] = b_rdata[b];
                    vif.dvalid[p] = 1'b1;
                end
            end
        end
    end

    assign vif.mdata = mb_rdata[msel_q];
    assign vif.mvalid = mvld_q;

endmodule

// ==== hw/vrf_cfg.svh ====
/* Sizes for the banked vector register file.
   Bank counts must be powers of two and divide the register and mask counts.
   The issue and collect logic assume exactly two data read ports. */
`ifndef VRF_CFG_SVH
`define VRF_CFG_SVH

// Data banks and ports
`define VRF_BANKS   4
`define VRF_RPORTS  2
`define VRF_WPORTS  2
`define VRF_NREGS   32
`define VRF_VLMAX   4

// Mask banks, one read and one write port
`define VRF_MBANKS  2
`define VRF_NMASKS  8

`endif

// ==== hw/vrf_collect.sv ====
/* Gathers read results that return in different cycles.
   o_opnd_valid pulses one cycle after the last expected result.
   A new request set may start in the cycle the previous one completes. */
`include "vrf_cfg.svh"

module vrf_collect
    import vrf_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    vrf_if.collect vif,
    output logic o_opnd_valid,
    output vreg_t o_src1,
    output vreg_t o_src2,
    output vmask_t o_mask
);

    logic active;
    logic [`VRF_RPORTS-1:0] exp_d, got_d, got_d_nxt;
    logic exp_m, got_m, got_m_nxt;
    logic done;
    vreg_t src_q [`VRF_RPORTS];
    vreg_t src_cur [`VRF_RPORTS];
    vmask_t mask_q, mask_cur;

    // Results arriving this cycle count as present
    always_comb begin
        got_d_nxt = got_d | vif.dvalid;
        got_m_nxt = got_m | vif.mvalid;
        for (int p = 0; p < `VRF_RPORTS; p++) begin
            src_cur[p] = vif.dvalid[p] ? vif.rdata[p] : src_q[p];
        end
        mask_cur = vif.mvalid ? vif.mdata : mask_q;
        done = active && ((exp_d & ~got_d_nxt) == '0) && (!exp_m || got_m_nxt);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            exp_d <= '0;
            exp_m <= 1'b0;
            got_d <= '0;
            got_m <= 1'b0;
            o_opnd_valid <= 1'b0;
        end else begin
            o_opnd_valid <= done;
            got_d <= got_d_nxt;
            got_m <= got_m_nxt;
            if (done) begin
                active <= 1'b0;
                got_d <= '0;
                got_m <= 1'b0;
            end
            if (vif.req_valid) begin
                active <= 1'b1;
                exp_d <= vif.req.ren;
                exp_m <= vif.req.mren;
                got_d <= '0;
                got_m <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        src_q <= src_cur;
        mask_q <= mask_cur;
        if (done) begin
            o_src1 <= src_cur[0];
            o_src2 <= src_cur[1];
            o_mask <= exp_m ? mask_cur : '0;
        end
    end

endmodule

// ==== hw/vrf_if.sv ====
/* Request and result bus between issue, register file and collector.
   req_valid may only be high while busy is low.
   dvalid and mvalid are single-cycle pulses. */
`include "vrf_cfg.svh"

interface vrf_if
    import vrf_pkg::*;
();

    vrf_req_t req;
    logic req_valid;
    logic busy;

    vreg_t [`VRF_RPORTS-1:0] rdata;
    logic [`VRF_RPORTS-1:0] dvalid;
    vmask_t mdata;
    logic mvalid;

    modport issue (
        output req, req_valid,
        input busy
    );

    modport regfile (
        input req, req_valid,
        output busy, rdata, dvalid, mdata, mvalid
    );

    modport collect (
        input req, req_valid, rdata, dvalid, mdata, mvalid
    );

endinterface

// ==== hw/vrf_issue.sv ====
/* Holds one accepted operation and launches it when the register file is free.
   Both source registers are always read; the mask read is optional.
   Only one operation is held, so o_op_ready is low until it launches. */
`include "vrf_cfg.svh"

module vrf_issue
    import vrf_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  logic i_op_valid,
    input  reg_idx_t i_vs1,
    input  reg_idx_t i_vs2,
    input  logic i_use_mask,
    input  mask_idx_t i_vm,
    input  logic [`VRF_WPORTS-1:0] i_wen,
    input  reg_idx_t [`VRF_WPORTS-1:0] i_vd,
    input  vreg_t [`VRF_WPORTS-1:0] i_wdata,
    input  logic i_mwen,
    input  mask_idx_t i_vmd,
    input  vmask_t i_mwdata,
    output logic o_op_ready,
    vrf_if.issue vif
);

    logic held;
    logic accept;
    vrf_req_t op_q;

    assign accept = i_op_valid && o_op_ready;
    assign o_op_ready = !held;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (vif.req_valid) begin
            held <= 1'b0;
        end
    end

    // Port 0 reads vs1, port 1 reads vs2
    always_ff @(posedge CLK) begin
        if (accept) begin
            op_q.ren <= '1;
            op_q.vs[0] <= i_vs1;
            op_q.vs[1] <= i_vs2;
            op_q.wen <= i_wen;
            op_q.vd <= i_vd;
            op_q.wdata <= i_wdata;
            op_q.mren <= i_use_mask;
            op_q.vms <= i_vm;
            op_q.mwen <= i_mwen;
            op_q.vmd <= i_vmd;
            op_q.mwdata <= i_mwdata;
        end
    end

    assign vif.req = op_q;
    assign vif.req_valid = held && !vif.busy;

endmodule

// ==== hw/vrf_pkg.sv ====
/* Types shared by the register file, the issue stage and the collector.
   Elements are raw bf16 bit patterns; no arithmetic is done on them. */
`include "vrf_cfg.svh"

package vrf_pkg;

    typedef logic [15:0] elem_t;
    typedef elem_t [`VRF_VLMAX-1:0] vreg_t;
    typedef logic [`VRF_VLMAX-1:0] vmask_t;

    typedef logic [$clog2(`VRF_NREGS)-1:0] reg_idx_t;
    typedef logic [$clog2(`VRF_NMASKS)-1:0] mask_idx_t;

    // One full set of register file requests
    typedef struct packed {
        logic [`VRF_RPORTS-1:0] ren;
        reg_idx_t [`VRF_RPORTS-1:0] vs;
        logic [`VRF_WPORTS-1:0] wen;
        reg_idx_t [`VRF_WPORTS-1:0] vd;
        vreg_t [`VRF_WPORTS-1:0] wdata;
        logic mren;
        mask_idx_t vms;
        logic mwen;
        mask_idx_t vmd;
        vmask_t mwdata;
    } vrf_req_t;

    typedef enum logic {
        READY,
        CONFLICT
    } conflict_state_t;

endpackage

// ==== hw/vrf_top.sv ====
/* Operand path top level: issue stage, banked register file, collector.
   One operation in flight at a time; latency is 3 or 4 cycles.
   o_src1, o_src2 and o_mask are valid while o_opnd_valid is high. */
`include "vrf_cfg.svh"

module vrf_top
    import vrf_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  logic i_op_valid,
    input  reg_idx_t i_vs1,
    input  reg_idx_t i_vs2,
    input  logic i_use_mask,
    input  mask_idx_t i_vm,
    input  logic [`VRF_WPORTS-1:0] i_wen,
    input  reg_idx_t [`VRF_WPORTS-1:0] i_vd,
    input  vreg_t [`VRF_WPORTS-1:0] i_wdata,
    input  logic i_mwen,
    input  mask_idx_t i_vmd,
    input  vmask_t i_mwdata,
    output logic o_op_ready,
    output logic o_opnd_valid,
    output vreg_t o_src1,
    output vreg_t o_src2,
    output vmask_t o_mask
);

    vrf_if vif ();

    vrf_issue issue_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .i_op_valid (i_op_valid),
        .i_vs1      (i_vs1),
        .i_vs2      (i_vs2),
        .i_use_mask (i_use_mask),
        .i_vm       (i_vm),
        .i_wen      (i_wen),
        .i_vd       (i_vd),
        .i_wdata    (i_wdata),
        .i_mwen     (i_mwen),
        .i_vmd      (i_vmd),
        .i_mwdata   (i_mwdata),
        .o_op_ready (o_op_ready),
        .vif        (vif.issue)
    );

    vrf_banked banked_i (
        .CLK  (CLK),
        .nRST (nRST),
        .vif  (vif.regfile)
    );

    vrf_collect collect_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .vif          (vif.collect),
        .o_opnd_valid (o_opnd_valid),
        .o_src1       (o_src1),
        .o_src2       (o_src2),
        .o_mask       (o_mask)
    );

endmodule

// ==== list.f ====
+incdir+hw
hw/vrf_pkg.sv
hw/vrf_if.sv
hw/vrf_bank.sv
hw/vrf_issue.sv
hw/vrf_banked.sv
hw/vrf_collect.sv
hw/vrf_top.sv
sim/vrf_assert.sv
sim/vrf_tb.sv

// ==== sim/vrf_assert.sv ====
/* Bound checker for vrf_top with a shadow register and mask file.
   Assumes one operation in flight at a time. Registers never written are
   not compared. fail_count is read by the testbench. */
`include "vrf_cfg.svh"

module vrf_assert
    import vrf_pkg::*;
(
    input logic CLK,
    input logic nRST,
    input logic i_op_valid,
    input reg_idx_t i_vs1,
    input reg_idx_t i_vs2,
    input logic i_use_mask,
    input mask_idx_t i_vm,
    input logic [`VRF_WPORTS-1:0] i_wen,
    input reg_idx_t [`VRF_WPORTS-1:0] i_vd,
    input vreg_t [`VRF_WPORTS-1:0] i_wdata,
    input logic i_mwen,
    input mask_idx_t i_vmd,
    input vmask_t i_mwdata,
    input logic o_op_ready,
    input logic o_opnd_valid,
    input vreg_t o_src1,
    input vreg_t o_src2,
    input vmask_t o_mask
);

    localparam int BW = $clog2(`VRF_BANKS);

    int fail_count = 0;
    vreg_t shadow [`VRF_NREGS];
    vmask_t mshadow [`VRF_NMASKS];
    logic [`VRF_NREGS-1:0] known;
    logic [`VRF_NMASKS-1:0] mknown;
    vreg_t exp1, exp2;
    vmask_t expm;
    logic k1, k2, km;
    int lat, exp_lat;
    logic accept;

    assign accept = i_op_valid && o_op_ready;

    // Expected reads see the file from before this operation's writes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            known <= '0;
            mknown <= '0;
            k1 <= 1'b0;
            k2 <= 1'b0;
            km <= 1'b0;
            lat <= 0;
            exp_lat <= 3;
        end else begin
            lat <= lat + 1;
            if (accept) begin
                exp1 <= shadow[i_vs1];
                exp2 <= shadow[i_vs2];
                k1 <= known[i_vs1];
                k2 <= known[i_vs2];
                expm <= i_use_mask ? mshadow[i_vm] : '0;
                km <= !i_use_mask || mknown[i_vm];
                lat <= 1;
                // Both reads in one bank costs one extra cycle
                exp_lat <= (i_vs1[BW-1:0] == i_vs2[BW-1:0]) ? 4 : 3;
                for (int p = 0; p < `VRF_WPORTS; p++) begin
                    if (i_wen[p]) begin
                        shadow[i_vd[p]] <= i_wdata[p];
                        known[i_vd[p]] <= 1'b1;
                    end
                end
                if (i_mwen) begin
                    mshadow[i_vmd] <= i_mwdata;
                    mknown[i_vmd] <= 1'b1;
                end
            end
        end
    end

    a_reset: assert property (@(posedge CLK) $rose(nRST) |-> o_op_ready && !o_opnd_valid)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t ready or valid wrong after reset", $time);
        end

    a_src1: assert property (@(posedge CLK) disable iff (!nRST)
        o_opnd_valid && k1 |-> o_src1 == exp1)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t src1 %h expected %h", $time, o_src1, exp1);
        end

    a_src2: assert property (@(posedge CLK) disable iff (!nRST)
        o_opnd_valid && k2 |-> o_src2 == exp2)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t src2 %h expected %h", $time, o_src2, exp2);
        end

    a_mask: assert property (@(posedge CLK) disable iff (!nRST)
        o_opnd_valid && km |-> o_mask == expm)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t mask %h expected %h", $time, o_mask, expm);
        end

    a_latency: assert property (@(posedge CLK) disable iff (!nRST)
        o_opnd_valid |-> lat == exp_lat)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t latency %0d expected %0d", $time, lat, exp_lat);
        end

    a_one_op: assert property (@(posedge CLK) disable iff (!nRST) accept |=> !o_op_ready)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t ready still high after acceptance", $time);
        end

endmodule

bind vrf_top vrf_assert assert_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .i_op_valid   (i_op_valid),
    .i_vs1        (i_vs1),
    .i_vs2        (i_vs2),
    .i_use_mask   (i_use_mask),
    .i_vm         (i_vm),
    .i_wen        (i_wen),
    .i_vd         (i_vd),
    .i_wdata      (i_wdata),
    .i_mwen       (i_mwen),
    .i_vmd        (i_vmd),
    .i_mwdata     (i_mwdata),
    .o_op_ready   (o_op_ready),
    .o_opnd_valid (o_opnd_valid),
    .o_src1       (o_src1),
    .o_src2       (o_src2),
    .o_mask       (o_mask)
);

// ==== sim/vrf_tb.sv ====
/* Testbench for vrf_top. One operation at a time, each waited for with a
   timeout. Data and latency are compared by the bound checker. */
`include "vrf_cfg.svh"

module vrf_tb
    import vrf_pkg::*;
();

    localparam int TIMEOUT = 50;

    logic CLK;
    logic nRST;
    logic i_op_valid;
    reg_idx_t i_vs1, i_vs2;
    logic i_use_mask;
    mask_idx_t i_vm;
    logic [`VRF_WPORTS-1:0] i_wen;
    reg_idx_t [`VRF_WPORTS-1:0] i_vd;
    vreg_t [`VRF_WPORTS-1:0] i_wdata;
    logic i_mwen;
    mask_idx_t i_vmd;
    vmask_t i_mwdata;
    logic o_op_ready, o_opnd_valid;
    vreg_t o_src1, o_src2;
    vmask_t o_mask;

    logic [15:0] lfsr;
    int tests_run, tests_failed, timeouts, fails_before;

    vrf_top vrf_top_i (.*);

    always #50 CLK = ~CLK;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic finish_run();
        int failures;
        failures = vrf_top_i.assert_i.fail_count + timeouts;
        $display("tests run %0d, tests failed %0d, assertion failures %0d, timeouts %0d",
                 tests_run, tests_failed, vrf_top_i.assert_i.fail_count, timeouts);
        if (tests_failed == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
        end while (!o_op_ready && cycles < TIMEOUT);
        if (!o_op_ready) begin
            $display("timeout: operation was never accepted, o_op_ready stayed low");
            timeouts++;
        end
    endtask

    task automatic wait_opnd();
        int cycles;
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
        end while (!o_opnd_valid && cycles < TIMEOUT);
        if (!o_opnd_valid) begin
            $display("timeout: o_opnd_valid never came after an accepted operation");
            timeouts++;
        end
    endtask

    // After a timeout no further operations are sent
    task automatic issue_op(input reg_idx_t vs1, input reg_idx_t vs2, input logic um,
                            input mask_idx_t vm, input logic [1:0] wen,
                            input reg_idx_t vd0, input reg_idx_t vd1,
                            input vreg_t wd0, input vreg_t wd1, input logic mw,
                            input mask_idx_t vmd, input vmask_t md);
        if (timeouts == 0) begin
            @(posedge CLK);
            i_op_valid <= 1'b1;
            i_vs1 <= vs1;
            i_vs2 <= vs2;
            i_use_mask <= um;
            i_vm <= vm;
            i_wen <= wen;
            i_vd[0] <= vd0;
            i_vd[1] <= vd1;
            i_wdata[0] <= wd0;
            i_wdata[1] <= wd1;
            i_mwen <= mw;
            i_vmd <= vmd;
            i_mwdata <= md;
            wait_ready();
            i_op_valid <= 1'b0;
            i_wen <= '0;
            i_mwen <= 1'b0;
            if (timeouts == 0) begin
                wait_opnd();
            end
        end
    endtask

    // Let the checker finish the last edge before counting
    task automatic end_test(input string name);
        int n;
        @(negedge CLK);
        n = vrf_top_i.assert_i.fail_count - fails_before;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d assertion failures", name, n);
        end
        fails_before = vrf_top_i.assert_i.fail_count;
    endtask

    initial begin
        logic [63:0] a, b, d0, d1;
        reg_idx_t r;
        CLK = 1'b0;
        nRST = 1'b0;
        i_op_valid = 1'b0;
        i_vs1 = '0;
        i_vs2 = '0;
        i_use_mask = 1'b0;
        i_vm = '0;
        i_wen = '0;
        i_vd = '0;
        i_wdata = '0;
        i_mwen = 1'b0;
        i_vmd = '0;
        i_mwdata = '0;
        lfsr = 16'd43;
        tests_run = 0;
        tests_failed = 0;
        timeouts = 0;
        fails_before = 0;

        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        repeat (2) @(posedge CLK);
        end_test("reset state");

        // Two registers in different banks per operation, one mask each
        for (int k = 0; k < 16; k++) begin
            rand_bits(64, d0);
            rand_bits(64, d1);
            rand_bits(5, a);
            rand_bits(4, b);
            issue_op(reg_idx_t'(a), reg_idx_t'(k), 1'b0, '0, 2'b11, reg_idx_t'(2 * k),
                     reg_idx_t'(2 * k + 1), d0, d1, k < 8, mask_idx_t'(k), vmask_t'(b));
        end
        for (int k = 0; k < 32; k++) begin
            rand_bits(5, a);
            issue_op(reg_idx_t'(k), reg_idx_t'(a), 1'b1, mask_idx_t'(k), '0, '0, '0,
                     '0, '0, 1'b0, '0, '0);
        end
        end_test("fill and read back");

        for (int k = 0; k < 8; k++) begin
            rand_bits(5, a);
            rand_bits(3, b);
            r = reg_idx_t'(a);
            issue_op(r, {b[2:0], r[1:0]}, 1'b0, '0, '0, '0, '0, '0, '0, 1'b0, '0, '0);
        end
        end_test("same bank reads");

        for (int k = 0; k < 4; k++) begin
            rand_bits(5, a);
            rand_bits(64, d0);
            rand_bits(64, d1);
            r = reg_idx_t'(a);
            issue_op(r + 5'd1, r + 5'd2, 1'b0, '0, 2'b11, r, r + 5'd4, d0, d1,
                     1'b0, '0, '0);
            issue_op(r, r + 5'd4, 1'b0, '0, '0, '0, '0, '0, '0, 1'b0, '0, '0);
        end
        end_test("same bank writes");

        for (int k = 0; k < 4; k++) begin
            rand_bits(5, a);
            rand_bits(64, d0);
            r = reg_idx_t'(a);
            issue_op(r, r + 5'd1, 1'b0, '0, 2'b01, r, '0, d0, '0, 1'b0, '0, '0);
            issue_op(r, r + 5'd1, 1'b0, '0, '0, '0, '0, '0, '0, 1'b0, '0, '0);
        end
        end_test("read and write same register");

        for (int k = 0; k < 4; k++) begin
            rand_bits(3, a);
            rand_bits(4, b);
            issue_op(reg_idx_t'(k), reg_idx_t'(k + 1), 1'b0, '0, '0, '0, '0, '0, '0,
                     1'b1, mask_idx_t'(a), vmask_t'(b));
            issue_op(reg_idx_t'(k), reg_idx_t'(k + 1), 1'b1, mask_idx_t'(a), '0, '0, '0,
                     '0, '0, 1'b0, '0, '0);
            issue_op(reg_idx_t'(k), reg_idx_t'(k + 1), 1'b0, mask_idx_t'(a), '0, '0, '0,
                     '0, '0, 1'b0, '0, '0);
        end
        end_test("masked and unmasked reads");

        finish_run();
    end

endmodule
